/* verilog/fetch_pkg.sv */
package fetch_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] inst_t;

	typedef struct packed {
		addr_t pc;
		inst_t inst;
	} fetch_pkt_t;

	// valid marks a retire beat in the stream
	typedef struct packed {
		addr_t pc;
		inst_t inst;
		logic  illegal;
		logic  valid;
	} retire_t;

	typedef struct packed {
		logic  valid;
		addr_t target;
	} redirect_t;

	typedef struct packed {
		addr_t addr;
		logic  valid;
	} axi_ar_t;

	typedef struct packed {
		inst_t      data;
		logic [1:0] resp;
		logic       valid;
	} axi_r_t;

	// supported major opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [2:0] F3_JALR = 3'b000;

	// branch conditions
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// load and store widths
	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;
	localparam logic [2:0] F3_SB  = 3'b000;
	localparam logic [2:0] F3_SH  = 3'b001;
	localparam logic [2:0] F3_SW  = 3'b010;

	// alu ops shared by OP and OP_IMM
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SRL = 3'b101;
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	// system group
	localparam logic [2:0] F3_PRIV  = 3'b000;
	localparam logic [2:0] F3_CSRRW = 3'b001;
	localparam logic [2:0] F3_CSRRS = 3'b010;
	localparam inst_t INST_ECALL  = 32'h0000_0073;
	localparam inst_t INST_EBREAK = 32'h0010_0073;
	localparam inst_t INST_MRET   = 32'h3020_0073;

endpackage

/* verilog/fetch_lfsr.sv */
`timescale 1ns/1ps

module fetch_lfsr (
	input  logic       clk,
	input  logic       rst,
	input  logic       step_i,
	output logic [3:0] value_o
);
	logic [3:0] state_q;
	logic       feedback;

	// x^4 + x^3 + 1 walks all 15 nonzero states
	assign feedback = state_q[3] ^ state_q[2];

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= 4'd1;
		end else if (step_i) begin
			state_q <= {state_q[2:0], feedback};
		end
	end

	assign value_o = state_q;

endmodule

/* verilog/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit import fetch_pkg::*; #(
	parameter int    QUEUE_DEPTH = 4,
	parameter addr_t RESET_PC    = '0
) (
	input  logic       clk,
	input  logic       rst,
	output axi_ar_t    ar_o,
	input  logic       ar_ready_i,
	input  axi_r_t     r_i,
	output logic       r_ready_o,
	output logic       push_o,
	output fetch_pkt_t pkt_o,
	input  logic       credit_i,
	input  redirect_t  jal_redir_i,
	input  redirect_t  ext_redir_i,
	output logic       flush_o
);
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	typedef enum logic [1:0] {
		S_CREDIT,
		S_ADDR,
		S_DATA,
		S_PUSH
	} state_e;

	state_e           state_q;
	state_e           state_d;
	addr_t            pc_q;
	addr_t            req_addr_q;
	fetch_pkt_t       pkt_q;
	logic [CNT_W-1:0] credit_q;
	logic             discard_q;
	logic [3:0]       delay_q;
	logic [3:0]       wait_q;
	logic [3:0]       lfsr_val;
	logic             load_delay;
	logic             ar_valid;
	logic             ar_fire;
	logic             r_fire;
	logic             redir_take;
	addr_t            redir_target;

	// external redirect has priority over jal
	assign redir_take   = ext_redir_i.valid | jal_redir_i.valid;
	assign redir_target = ext_redir_i.valid ? ext_redir_i.target : jal_redir_i.target;
	assign flush_o      = redir_take;

	// handshakes open once the random gap has elapsed
	assign ar_valid  = (state_q == S_ADDR) && (wait_q == delay_q);
	assign r_ready_o = (state_q == S_DATA) && (wait_q == delay_q);
	assign ar_fire   = ar_valid & ar_ready_i;
	assign r_fire    = r_ready_o & r_i.valid;
	assign ar_o      = '{addr: req_addr_q, valid: ar_valid};

	// wrong-path packet is dropped on a redirect
	assign push_o = (state_q == S_PUSH) & ~redir_take;
	assign pkt_o  = pkt_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_CREDIT: begin
				if (!redir_take && credit_q != '0) begin
					state_d = S_ADDR;
				end
			end
			S_ADDR: begin
				if (ar_fire) begin
					state_d = S_DATA;
				end
			end
			S_DATA: begin
				if (r_fire) begin
					if (discard_q || redir_take) begin
						state_d = S_CREDIT;
					end else if (r_i.resp != 2'b00) begin
						// retry same address
						state_d = S_ADDR;
					end else begin
						state_d = S_PUSH;
					end
				end
			end
			default: begin
				state_d = S_CREDIT;
			end
		endcase
	end

	// new delay drawn on entry to each handshake phase
	assign load_delay = (state_d != state_q) && (state_d == S_ADDR || state_d == S_DATA);

	fetch_lfsr u_lfsr (
		.clk     (clk),
		.rst     (rst),
		.step_i  (load_delay),
		.value_o (lfsr_val)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q   <= S_CREDIT;
			pc_q      <= RESET_PC;
			credit_q  <= CNT_W'(QUEUE_DEPTH);
			discard_q <= 1'b0;
			delay_q   <= 4'd0;
			wait_q    <= 4'd0;
		end else begin
			state_q <= state_d;

			if (load_delay) begin
				delay_q <= lfsr_val;
				wait_q  <= 4'd0;
			end else if (wait_q != delay_q) begin
				wait_q <= wait_q + 4'd1;
			end

			// flush empties the queue, so every slot is free again
			if (redir_take) begin
				credit_q <= CNT_W'(QUEUE_DEPTH);
			end else begin
				credit_q <= credit_q - CNT_W'(push_o) + CNT_W'(credit_i);
			end

			if (redir_take) begin
				pc_q <= redir_target;
			end else if (r_fire && !discard_q && r_i.resp == 2'b00) begin
				pc_q <= pc_q + 32'd4;
			end

			// read in flight at redirect time completes and is dropped
			if (r_fire) begin
				discard_q <= 1'b0;
			end else if (redir_take && (state_q == S_ADDR || state_q == S_DATA)) begin
				discard_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == S_CREDIT && state_d == S_ADDR) begin
			req_addr_q <= pc_q;
		end
		if (r_fire) begin
			pkt_q <= '{pc: req_addr_q, inst: r_i.data};
		end
	end

	credit_guard: assert property (@(posedge clk) disable iff (rst)
		ar_o.valid |-> credit_q != '0);

endmodule

/* verilog/fetch_queue.sv */
`timescale 1ns/1ps

module fetch_queue import fetch_pkg::*; #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       push_i,
	input  fetch_pkt_t pkt_i,
	input  logic       pop_i,
	input  logic       flush_i,
	output fetch_pkt_t head_o,
	output logic       empty_o
);
	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	fetch_pkt_t       mem_q [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic             full;

	assign full    = (count_q == CNT_W'(QUEUE_DEPTH));
	assign empty_o = (count_q == '0);
	assign head_o  = mem_q[rd_ptr_q];

	// pointers wrap on their own since depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else if (flush_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop_i) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop_i);
		end
	end

	always_ff @(posedge clk) begin
		if (push_i && !flush_i) begin
			mem_q[wr_ptr_q] <= pkt_i;
		end
	end

	// credit scheme in fetch_unit keeps these true
	no_overflow: assert property (@(posedge clk) disable iff (rst)
		push_i |-> !full);

	no_underflow: assert property (@(posedge clk) disable iff (rst)
		pop_i |-> !empty_o);

endmodule

/* verilog/inst_checker.sv */
`timescale 1ns/1ps

module inst_checker import fetch_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  fetch_pkt_t head_i,
	input  logic       empty_i,
	output logic       pop_o,
	output logic       credit_o,
	input  redirect_t  ext_redir_i,
	output redirect_t  jal_redir_o,
	output retire_t    retire_o
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       illegal;
	logic       jal_hit;
	addr_t      jal_imm;
	fetch_pkt_t ret_pkt_q;
	logic       ret_illegal_q;
	logic       ret_valid_q;
	logic       jal_valid_q;
	addr_t      jal_target_q;

	assign opcode = head_i.inst[6:0];
	assign funct3 = head_i.inst[14:12];
	assign funct7 = head_i.inst[31:25];

	always_comb begin
		illegal = 1'b1;
		case (opcode)
			OPC_LUI, OPC_AUIPC, OPC_JAL: begin
				illegal = 1'b0;
			end
			OPC_JALR: begin
				illegal = (funct3 != F3_JALR);
			end
			OPC_BRANCH: begin
				illegal = !(funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU});
			end
			OPC_LOAD: begin
				illegal = !(funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU});
			end
			OPC_STORE: begin
				illegal = !(funct3 inside {F3_SB, F3_SH, F3_SW});
			end
			OPC_OP_IMM: begin
				// only shifts carry a funct7 field
				if (funct3 == F3_SLL) begin
					illegal = (funct7 != F7_BASE);
				end else if (funct3 == F3_SRL) begin
					illegal = !(funct7 inside {F7_BASE, F7_ALT});
				end else begin
					illegal = 1'b0;
				end
			end
			OPC_OP: begin
				// sub and sra use the alternate funct7
				if (funct3 == F3_ADD || funct3 == F3_SRL) begin
					illegal = !(funct7 inside {F7_BASE, F7_ALT});
				end else begin
					illegal = (funct7 != F7_BASE);
				end
			end
			OPC_SYSTEM: begin
				if (funct3 == F3_PRIV) begin
					illegal = !(head_i.inst inside {INST_ECALL, INST_EBREAK, INST_MRET});
				end else begin
					illegal = !(funct3 inside {F3_CSRRW, F3_CSRRS});
				end
			end
			default: begin
				illegal = 1'b1;
			end
		endcase
	end

	// sign-extended J-type immediate
	assign jal_imm = {{11{head_i.inst[31]}}, head_i.inst[31], head_i.inst[19:12],
		head_i.inst[20], head_i.inst[30:21], 1'b0};
	assign jal_hit = (opcode == OPC_JAL) && !illegal;

	// hold off while any redirect is being taken
	assign pop_o    = !empty_i && !ext_redir_i.valid && !jal_valid_q;
	assign credit_o = pop_o;

	always_ff @(posedge clk) begin
		if (rst) begin
			ret_valid_q <= 1'b0;
			jal_valid_q <= 1'b0;
		end else begin
			ret_valid_q <= pop_o;
			jal_valid_q <= pop_o & jal_hit;
		end
	end

	always_ff @(posedge clk) begin
		if (pop_o) begin
			ret_pkt_q     <= head_i;
			ret_illegal_q <= illegal;
			jal_target_q  <= head_i.pc + jal_imm;
		end
	end

	assign retire_o = '{pc: ret_pkt_q.pc, inst: ret_pkt_q.inst,
		illegal: ret_illegal_q, valid: ret_valid_q};
	assign jal_redir_o = '{valid: jal_valid_q, target: jal_target_q};

	// a taken jal blocks pops until fetch_unit flushes
	jal_stops_pop: assert property (@(posedge clk) disable iff (rst)
		jal_redir_o.valid |-> !pop_o);

endmodule

/* verilog/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
	parameter int    QUEUE_DEPTH = 4,
	parameter addr_t RESET_PC    = '0
) (
	input  logic      clk,
	input  logic      rst,
	output axi_ar_t   ar_o,
	input  logic      ar_ready_i,
	input  axi_r_t    r_i,
	output logic      r_ready_o,
	input  redirect_t redirect_i,
	output retire_t   retire_o
);
	logic       push;
	fetch_pkt_t push_pkt;
	logic       pop;
	logic       credit;
	logic       flush;
	logic       empty;
	fetch_pkt_t head;
	redirect_t  jal_redir;

	fetch_unit #(
		.QUEUE_DEPTH (QUEUE_DEPTH),
		.RESET_PC    (RESET_PC)
	) u_fetch_unit (
		.clk         (clk),
		.rst         (rst),
		.ar_o        (ar_o),
		.ar_ready_i  (ar_ready_i),
		.r_i         (r_i),
		.r_ready_o   (r_ready_o),
		.push_o      (push),
		.pkt_o       (push_pkt),
		.credit_i    (credit),
		.jal_redir_i (jal_redir),
		.ext_redir_i (redirect_i),
		.flush_o     (flush)
	);

	fetch_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_fetch_queue (
		.clk     (clk),
		.rst     (rst),
		.push_i  (push),
		.pkt_i   (push_pkt),
		.pop_i   (pop),
		.flush_i (flush),
		.head_o  (head),
		.empty_o (empty)
	);

	inst_checker u_inst_checker (
		.clk         (clk),
		.rst         (rst),
		.head_i      (head),
		.empty_i     (empty),
		.pop_o       (pop),
		.credit_o    (credit),
		.ext_redir_i (redirect_i),
		.jal_redir_o (jal_redir),
		.retire_o    (retire_o)
	);

endmodule

/* verif/tb_axi_mem.sv */
`timescale 1ns/1ps

module tb_axi_mem import fetch_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  axi_ar_t ar_i,
	output logic    ar_ready_o,
	output axi_r_t  r_o,
	input  logic    r_ready_i
);
	localparam int MEM_WORDS = 256;

	typedef enum logic [1:0] {
		M_ADDR,
		M_DATA,
		M_RESP
	} phase_e;

	inst_t       mem [MEM_WORDS];
	phase_e      phase;
	logic [31:0] lcg_state;
	int          gap;
	addr_t       addr_q;

	function automatic logic [31:0] lcg_step(logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic clear_mem();
		for (int i = 0; i < MEM_WORDS; i++) begin
			// illegal opcode with the word index in the upper bits
			mem[i] = {~8'(i), 8'(i), 9'h000, 7'h7f};
		end
	endtask

	task automatic load_word(addr_t addr, inst_t data);
		mem[addr[9:2]] = data;
	endtask

	initial begin
		ar_ready_o = 1'b0;
		r_o        = '0;
	end

	always @(posedge clk) begin
		if (rst) begin
			ar_ready_o <= 1'b0;
			r_o        <= '0;
			phase      <= M_ADDR;
			gap        <= 0;
			lcg_state  <= 32'he1e06418;
		end else begin
			case (phase)
				M_ADDR: begin
					if (ar_ready_o) begin
						// valid is held, so the address beat completes here
						ar_ready_o <= 1'b0;
						addr_q     <= ar_i.addr;
						lcg_state  <= lcg_step(lcg_state);
						gap        <= int'(lcg_state[17:16]);
						phase      <= M_DATA;
					end else if (ar_i.valid) begin
						if (gap == 0) begin
							ar_ready_o <= 1'b1;
						end else begin
							gap <= gap - 1;
						end
					end
				end
				M_DATA: begin
					if (gap == 0) begin
						lcg_state <= lcg_step(lcg_state);
						// about one read in eight comes back with SLVERR and junk data
						if (lcg_state[20:18] == 3'd0) begin
							r_o <= '{data: ~mem[addr_q[9:2]], resp: 2'b10, valid: 1'b1};
						end else begin
							r_o <= '{data: mem[addr_q[9:2]], resp: 2'b00, valid: 1'b1};
						end
						phase <= M_RESP;
					end else begin
						gap <= gap - 1;
					end
				end
				default: begin
					if (r_ready_i) begin
						r_o       <= '0;
						lcg_state <= lcg_step(lcg_state);
						gap       <= int'(lcg_state[17:16]);
						phase     <= M_ADDR;
					end
				end
			endcase
		end
	end

endmodule

/* verif/tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top import fetch_pkg::*; ();
	localparam int    QUEUE_DEPTH    = 4;
	localparam addr_t RESET_PC       = 32'h0000_0000;
	localparam int    STIM_WORDS     = 256;
	localparam int    IMG_WORDS      = 256;
	localparam int    RETIRE_TIMEOUT = 2000;
	localparam int    MAX_TOLERATED  = 64;
	localparam int    MAX_PATH       = 1000;

	logic      clk;
	logic      rst;
	axi_ar_t   ar;
	logic      ar_ready;
	axi_r_t    r;
	logic      r_ready;
	redirect_t redirect;
	retire_t   retire;

	logic [31:0] stim [STIM_WORDS];
	inst_t       img_word [IMG_WORDS];
	logic        img_ill [IMG_WORDS];
	logic        img_valid [IMG_WORDS];
	int          redir_cnt [$];
	addr_t       redir_tgt [$];

	int pc_errors;
	int inst_errors;
	int ill_errors;
	int other_errors;

	fetch_top #(
		.QUEUE_DEPTH (QUEUE_DEPTH),
		.RESET_PC    (RESET_PC)
	) u_dut (
		.clk        (clk),
		.rst        (rst),
		.ar_o       (ar),
		.ar_ready_i (ar_ready),
		.r_i        (r),
		.r_ready_o  (r_ready),
		.redirect_i (redirect),
		.retire_o   (retire)
	);

	tb_axi_mem u_mem (
		.clk        (clk),
		.rst        (rst),
		.ar_i       (ar),
		.ar_ready_o (ar_ready),
		.r_o        (r),
		.r_ready_i  (r_ready)
	);

	always #10 clk = ~clk;

	function automatic logic listed(addr_t pc);
		return (pc < 32'(IMG_WORDS * 4)) && img_valid[pc[9:2]];
	endfunction

	// J-type offset from the ISA bit layout
	function automatic addr_t jal_offset(inst_t w);
		return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
	endfunction

	function automatic addr_t next_pc(addr_t pc);
		inst_t w;
		w = img_word[pc[9:2]];
		if (!img_ill[pc[9:2]] && w[6:0] == 7'b1101111) begin
			return pc + jal_offset(w);
		end
		return pc + 32'd4;
	endfunction

	// walk the program with redirects applied up to the first unlisted word
	function automatic int path_length();
		addr_t pc;
		int    n;
		int    ri;
		pc = RESET_PC;
		n  = 0;
		ri = 0;
		while (listed(pc) && n < MAX_PATH) begin
			n++;
			if (ri < redir_cnt.size() && redir_cnt[ri] == n) begin
				pc = redir_tgt[ri];
				ri++;
			end else begin
				pc = next_pc(pc);
			end
		end
		return n;
	endfunction

	task automatic load_stim();
		logic [31:0] kind;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		for (int i = 0; i < STIM_WORDS; i++) begin
			stim[i] = '1;
		end
		for (int i = 0; i < IMG_WORDS; i++) begin
			img_word[i]  = '0;
			img_ill[i]   = 1'b1;
			img_valid[i] = 1'b0;
		end
		$readmemh("verif/fetch_stim.txt", stim);
		u_mem.clear_mem();
		for (int rec = 0; rec < STIM_WORDS / 4; rec++) begin
			kind = stim[4 * rec];
			a    = stim[4 * rec + 1];
			b    = stim[4 * rec + 2];
			c    = stim[4 * rec + 3];
			if (kind == 32'd0) begin
				img_word[a[9:2]]  = b;
				img_ill[a[9:2]]   = c[0];
				img_valid[a[9:2]] = 1'b1;
				u_mem.load_word(a, b);
			end else if (kind == 32'd1) begin
				redir_cnt.push_back(int'(a));
				redir_tgt.push_back(b);
			end
		end
	endtask

	// redirect is a one-cycle pulse unless the caller drives it again
	task automatic wait_retire(output logic got, output retire_t seen);
		int idle;
		got  = 1'b0;
		seen = '0;
		idle = 0;
		while (!got && idle < RETIRE_TIMEOUT) begin
			@(posedge clk);
			redirect <= '0;
			if (retire.valid) begin
				got  = 1'b1;
				seen = retire;
			end else begin
				idle++;
			end
		end
	endtask

	task automatic check_retire(retire_t seen, addr_t exp_pc);
		inst_t exp_word;
		logic  exp_ill;
		exp_word = img_word[exp_pc[9:2]];
		exp_ill  = img_ill[exp_pc[9:2]];
		assert (seen.pc == exp_pc) else begin
			pc_errors++;
			$display("ERROR %0t: retire pc %h, expected %h", $time, seen.pc, exp_pc);
		end
		assert (seen.inst == exp_word) else begin
			inst_errors++;
			$display("ERROR %0t: inst %h at pc %h, expected %h",
				$time, seen.inst, exp_pc, exp_word);
		end
		assert (seen.illegal == exp_ill) else begin
			ill_errors++;
			$display("ERROR %0t: illegal flag %0b at pc %h, expected %0b",
				$time, seen.illegal, exp_pc, exp_ill);
		end
	endtask

	initial begin
		retire_t seen;
		logic    got;
		logic    tolerating;
		addr_t   exp_pc;
		int      checked;
		int      tolerated;
		int      path_len;
		int      ri;
		int      total;
		clk          = 1'b0;
		rst          = 1'b1;
		redirect     = '0;
		pc_errors    = 0;
		inst_errors  = 0;
		ill_errors   = 0;
		other_errors = 0;
		load_stim();
		path_len = path_length();
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		exp_pc     = RESET_PC;
		checked    = 0;
		tolerated  = 0;
		tolerating = 1'b0;
		ri         = 0;
		while (checked < path_len) begin
			wait_retire(got, seen);
			if (!got) begin
				other_errors++;
				$display("timeout: nothing retired for %0d cycles after %0d of %0d retires",
					RETIRE_TIMEOUT, checked, path_len);
				break;
			end
			// old-path retires are expected until the redirect target shows up
			if (tolerating && seen.pc != exp_pc) begin
				tolerated++;
				if (tolerated > MAX_TOLERATED) begin
					other_errors++;
					$display("redirect target %h never retired", exp_pc);
					break;
				end
			end else begin
				tolerating = 1'b0;
				check_retire(seen, exp_pc);
				checked++;
				if (ri < redir_cnt.size() && redir_cnt[ri] == checked) begin
					redirect   <= '{valid: 1'b1, target: redir_tgt[ri]};
					exp_pc     = redir_tgt[ri];
					tolerating = 1'b1;
					tolerated  = 0;
					ri++;
				end else begin
					exp_pc = next_pc(exp_pc);
				end
			end
		end

		total = pc_errors + inst_errors + ill_errors + other_errors;
		$display("retired %0d of %0d, errors: pc %0d, inst %0d, illegal %0d, other %0d",
			checked, path_len, pc_errors, inst_errors, ill_errors, other_errors);
		if (total == 0 && checked == path_len) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* verif/fetch_stim.txt */
// kind 0, memory word:  0 <addr> <word> <illegal>
// kind 1, redirect:     1 <retire count, hex> <target> 0
0 00000000 00500093 0 // addi x1, x0, 5
0 00000004 12345137 0 // lui
0 00000008 00001197 0 // auipc
0 0000000c 00208233 0 // add
0 00000010 402082b3 0 // sub
0 00000014 0000007f 1 // unknown opcode
0 00000018 00208463 0 // beq
0 0000001c 0020a463 1 // branch funct3 010
0 00000020 0040a303 0 // lw
0 00000024 0040b303 1 // ld, not rv32
0 00000028 0060a423 0 // sw
0 0000002c 0060b423 1 // sd, not rv32
0 00000030 010000ef 0 // jal x1, +16
0 00000034 ffffffff 1 // skipped by the jal
0 00000038 00000000 1
0 0000003c 0000007f 1
0 00000040 00309093 0 // slli
0 00000044 4020d093 0 // srai
0 00000048 40309093 1 // slli with alternate funct7
0 0000004c 0220d093 1 // srli with bad funct7
0 00000050 02208233 1 // mul
0 00000054 00008067 0 // jalr
0 00000058 00009067 1 // jalr funct3 001
0 0000005c 00000073 0 // ecall
0 00000060 00100073 0 // ebreak
0 00000064 30200073 0 // mret
0 00000068 300023f3 0 // csrrs
0 0000006c 30509073 0 // csrrw
0 00000070 10500073 1 // wfi
0 00000074 00004073 1 // system funct3 100
0 00000078 0080006f 0 // j +8
0 0000007c ffffffff 1
0 00000080 00500093 0
0 00000084 00208233 0
0 00000088 00000000 1
0 0000008c 00000013 0
0 00000200 00500093 0
0 00000204 010000ef 0 // jal +16, overridden by the second redirect
0 00000214 00000013 0
0 00000300 00000013 0
0 00000304 12345137 0
0 00000308 f81ff06f 0 // j -128
0 00000288 00208233 0
0 0000028c 0000007f 1
0 00000290 00000013 0
1 0000001e 00000200 0 // after retire 30
1 00000020 00000300 0 // after retire 32, the jal

/* sim.f */
verilog/fetch_pkg.sv
verilog/fetch_lfsr.sv
verilog/fetch_unit.sv
verilog/fetch_queue.sv
verilog/inst_checker.sv
verilog/fetch_top.sv
verif/tb_axi_mem.sv
verif/tb_fetch_top.sv
